//--- design/z3_pkg.sv
// zorro iii memory card shared definitions: address views, config rom, states, lane mapping
package z3_pkg;

	// on-chip ram geometry
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = 8;

	// autoconfig space page and register offsets (address bits 8..2)
	localparam logic [15:0] CFG_PAGE       = 16'hff00;
	localparam logic [6:0]  CFG_BASE_OFS   = 7'h44;
	localparam logic [6:0]  CFG_SHUTUP_OFS = 7'h4c;

	// true rom nibbles, pairs at even offsets
	// type a1 (z3, memory list, 32 MB), product 42, flags 30, manufacturer 07db
	localparam logic [3:0] CFG_ROM [64] = '{
		4'ha, 4'h0, 4'h1, 4'h0, 4'h4, 4'h0, 4'h2, 4'h0,
		4'h3, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h0, 4'h7, 4'h0, 4'hd, 4'h0, 4'hb, 4'h0,
		4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0
	};

	// card space view of the latched address
	typedef struct packed {
		logic [6:0]        region;
		logic [14:0]       rsvd;
		logic [RAM_AW-1:0] idx;
		logic [1:0]        lo;
	} z3_card_view_t;

	// config space view of the same word
	typedef struct packed {
		logic [15:0] page;
		logic [6:0]  mid;
		logic [6:0]  ofs;
		logic [1:0]  lo;
	} z3_cfg_view_t;

	typedef union packed {
		z3_card_view_t card;
		z3_cfg_view_t  cfg;
	} z3_addr_u;

	typedef enum logic [2:0] {IDLE, MATCH, DATA, WRITE, DTACK} z3_state_e;

	// logical word is ad[31:24], sd[7:0], ad[23:8]
	function automatic logic [31:0] lanes_to_word(input logic [31:8] ad, input logic [7:0] sd);
		return {ad[31:24], sd, ad[23:8]};
	endfunction

	// returns {ad[31:8], sd[7:0]}
	function automatic logic [31:0] word_to_lanes(input logic [31:0] w);
		return {w[31:24], w[15:0], w[23:16]};
	endfunction

endpackage

//--- design/mem_req_if.sv
// card memory request/response channel between cycle FSM and on-chip ram
interface mem_req_if;
	import z3_pkg::*;

	// request side
	logic              req_valid;
	logic              req_ready;
	logic              we;
	logic [RAM_AW-1:0] idx;
	logic [31:0]       wdata;
	logic [3:0]        be;
	// read response, one cycle after the read transfer
	logic              rsp_valid;
	logic [31:0]       rsp_data;

	modport master (
		output req_valid, we, idx, wdata, be,
		input  req_ready, rsp_valid, rsp_data
	);

	modport slave (
		input  req_valid, we, idx, wdata, be,
		output req_ready, rsp_valid, rsp_data
	);
endinterface

//--- design/z3_bus_sampler.sv
// bus sampler: resamples zorro iii strobes, latches the multiplexed address, builds write data
module z3_bus_sampler (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              nfcs_i,
	input  logic              doe_i,
	input  logic [3:0]        nds_i,
	input  logic [31:8]       ad_i,
	input  logic [7:2]        a_i,
	input  logic [7:0]        sd_i,
	output logic              nfcs_q_o,
	output logic              doe_q_o,
	output logic [3:0]        nds_q_o,
	output z3_pkg::z3_addr_u  addr_o,
	output logic [31:0]       wdata_o
);
	import z3_pkg::*;

	logic fcs_fall;

	// strobe low now, previous sample still high
	assign fcs_fall = nfcs_q_o && !nfcs_i;

	// one cycle of latency on the strobes
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			nfcs_q_o <= 1'b1;
			doe_q_o  <= 1'b0;
			nds_q_o  <= 4'hf;
		end else begin
			nfcs_q_o <= nfcs_i;
			doe_q_o  <= doe_i;
			nds_q_o  <= nds_i;
		end
	end

	// ad lines go away soon after nfcs falls
	// a[7:2] stays valid but is taken in the same word
	always_ff @(posedge clk) begin
		if (fcs_fall) begin
			addr_o <= {ad_i, a_i, 2'b00};
		end
	end

	// data lanes into the logical word, every edge
	always_ff @(posedge clk) begin
		wdata_o <= lanes_to_word(ad_i, sd_i);
	end

endmodule

//--- design/z3_slave_fsm.sv
// zorro iii slave cycle FSM: space decode, slave select, acknowledge and read data drive
module z3_slave_fsm (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             nfcs_i,
	input  logic             nfcs_q_i,
	input  logic             doe_q_i,
	input  logic             read_i,
	input  logic [1:0]       fc_i,
	input  logic [3:0]       nds_q_i,
	input  z3_pkg::z3_addr_u addr_i,
	input  logic [31:0]      wdata_i,
	input  logic             card_en_i,
	input  logic [31:25]     card_base_i,
	input  logic             cfg_en_i,
	input  logic [3:0]       cfg_nibble_i,
	mem_req_if.master        mem,
	output logic             nslave_o,
	output logic             ndtack_o,
	output logic             data_oe_o,
	output logic [31:8]      ad_o,
	output logic [7:0]       sd_o,
	output logic             cfg_wr_o
);
	import z3_pkg::*;

	z3_state_e   state;
	logic        card_cyc;
	logic        card_hit;
	logic        cfg_hit;
	logic        start;
	logic        rd_load;
	logic [31:0] rdata;

	assign card_hit = card_en_i && (addr_i.card.region == card_base_i);
	assign cfg_hit  = cfg_en_i && (addr_i.cfg.page == CFG_PAGE);
	// equal fc bits are cpu or reserved space
	assign start = !nfcs_q_i && (fc_i[0] ^ fc_i[1]) && (card_hit || cfg_hit);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state    <= IDLE;
			card_cyc <= 1'b0;
		end else if (nfcs_i) begin
			// master ended or aborted the cycle
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (start) begin
					state    <= MATCH;
					card_cyc <= card_hit;
				end
				MATCH: if (doe_q_i) state <= DATA;
				DATA: begin
					if (read_i) begin
						if (!card_cyc || mem.rsp_valid) state <= DTACK;
					end else if (nds_q_i != 4'hf) begin
						state <= WRITE;
					end
				end
				WRITE: if (!card_cyc || mem.req_ready) state <= DTACK;
				DTACK: if (nfcs_q_i) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// slave select low from match entry until nfcs seen high
	always_ff @(posedge clk) begin
		if (!rst_n_i) nslave_o <= 1'b1;
		else if (nfcs_q_i) nslave_o <= 1'b1;
		else if (state == IDLE && start && !nfcs_i) nslave_o <= 1'b0;
	end

	// read word from ram response or rom nibble on top bits
	assign rd_load = (state == DATA) && read_i && (!card_cyc || mem.rsp_valid);
	always_ff @(posedge clk) begin
		if (rd_load) rdata <= card_cyc ? mem.rsp_data : {cfg_nibble_i, 28'h0};
	end

	assign {ad_o, sd_o} = word_to_lanes(rdata);
	assign data_oe_o    = !nslave_o && doe_q_i && read_i;
	assign ndtack_o     = !((state == DTACK) && !nfcs_i);
	assign cfg_wr_o     = (state == WRITE) && !card_cyc;

	// card ram requests, reads in DATA and writes in WRITE
	assign mem.req_valid = card_cyc && (((state == DATA) && read_i) || (state == WRITE));
	assign mem.we        = (state == WRITE);
	assign mem.idx       = addr_i.card.idx;
	assign mem.wdata     = wdata_i;
	assign mem.be        = ~nds_q_i;

	// acknowledge only inside a selected cycle
	a_dtack_in_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
		!ndtack_o |-> !nslave_o);

endmodule

//--- design/z3_autoconfig.sv
// autoconfig: config rom nibbles, base and shut-up registers, configuration chain
module z3_autoconfig (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             ncfgin_i,
	input  logic             sensez3_i,
	input  logic             cfg_wr_i,
	input  z3_pkg::z3_addr_u addr_i,
	input  logic [31:0]      wdata_i,
	output logic             cfg_en_o,
	output logic [3:0]       cfg_nibble_o,
	output logic             card_en_o,
	output logic [31:25]     card_base_o,
	output logic             ncfgout_o
);
	import z3_pkg::*;

	logic       configured;
	logic       shutup;
	logic       base_wr;
	logic       shutup_wr;
	logic [6:0] ofs;
	logic [3:0] rom_nib;

	assign ofs = addr_i.cfg.ofs;

	// only 64 entries, upper half reads zero
	assign rom_nib = ofs[6] ? 4'h0 : CFG_ROM[ofs[5:0]];
	// type register pair goes out true, the rest inverted
	assign cfg_nibble_o = ((ofs == 7'h00) || (ofs == 7'h02)) ? rom_nib : ~rom_nib;

	assign base_wr   = cfg_wr_i && (ofs == CFG_BASE_OFS);
	assign shutup_wr = cfg_wr_i && (ofs == CFG_SHUTUP_OFS);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			configured <= 1'b0;
			shutup     <= 1'b0;
		end else if (!configured && !shutup) begin
			if (base_wr) configured <= 1'b1;
			else if (shutup_wr) shutup <= 1'b1;
		end
	end

	// base byte comes on d31..24, card spans 32 MB so d24 is dropped
	always_ff @(posedge clk) begin
		if (base_wr && !configured && !shutup) begin
			card_base_o <= wdata_i[31:25];
		end
	end

	// chain out, pass-through on a non-z3 backplane
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ncfgout_o <= 1'b1;
		end else if (sensez3_i) begin
			ncfgout_o <= !(configured || shutup);
		end else begin
			ncfgout_o <= ncfgin_i;
		end
	end

	// config space only while first unconfigured card in chain
	assign cfg_en_o  = !configured && !shutup && !ncfgin_i && sensez3_i;
	assign card_en_o = configured && sensez3_i;

	a_cfg_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(configured && shutup));

endmodule

//--- design/z3_card_ram.sv
// card memory: byte-strobed word ram with one-cycle read response
module z3_card_ram (
	input logic       clk,
	input logic       rst_n_i,
	mem_req_if.slave  mem
);
	import z3_pkg::*;

	logic [31:0] ram [RAM_WORDS];
	logic        xfer;

	// busy while the read response is out
	assign mem.req_ready = !mem.rsp_valid;
	assign xfer          = mem.req_valid && mem.req_ready;

	always_ff @(posedge clk) begin
		if (!rst_n_i) mem.rsp_valid <= 1'b0;
		else mem.rsp_valid <= xfer && !mem.we;
	end

	always_ff @(posedge clk) begin
		if (xfer && !mem.we) mem.rsp_data <= ram[mem.idx];
	end

	// byte lanes written only where strobed
	always_ff @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (xfer && mem.we && mem.be[b]) begin
				ram[mem.idx][8*b +: 8] <= mem.wdata[8*b +: 8];
			end
		end
	end

	// read transfer blocks the next cycle
	a_one_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		(xfer && !mem.we) |=> !(mem.req_valid && mem.req_ready));

endmodule

//--- design/z3_memcard.sv
// zorro iii memory card top: sampler, cycle FSM, autoconfig and on-chip ram
module z3_memcard (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        nfcs_i,
	input  logic        doe_i,
	input  logic        read_i,
	input  logic [1:0]  fc_i,
	input  logic [3:0]  nds_i,
	input  logic [31:8] ad_i,
	input  logic [7:2]  a_i,
	input  logic [7:0]  sd_i,
	input  logic        ncfgin_i,
	input  logic        iorst_n_i,
	input  logic        sensez3_i,
	output logic        nslave_o,
	output logic        ndtack_o,
	output logic        ncfgout_o,
	output logic [31:8] ad_o,
	output logic [7:0]  sd_o,
	output logic        data_oe_o
);
	import z3_pkg::*;

	logic         rst_n;
	logic         nfcs_q;
	logic         doe_q;
	logic [3:0]   nds_q;
	z3_addr_u     addr;
	logic [31:0]  wdata;
	logic         card_en;
	logic [31:25] card_base;
	logic         cfg_en;
	logic [3:0]   cfg_nibble;
	logic         cfg_wr;

	// backplane reset also clears autoconfig
	assign rst_n = rst_n_i && iorst_n_i;

	mem_req_if i_mem ();

	z3_bus_sampler i_sampler (
		.clk(clk), .rst_n_i(rst_n), .nfcs_i(nfcs_i), .doe_i(doe_i), .nds_i(nds_i),
		.ad_i(ad_i), .a_i(a_i), .sd_i(sd_i), .nfcs_q_o(nfcs_q), .doe_q_o(doe_q),
		.nds_q_o(nds_q), .addr_o(addr), .wdata_o(wdata)
	);

	z3_slave_fsm i_fsm (
		.clk(clk), .rst_n_i(rst_n), .nfcs_i(nfcs_i), .nfcs_q_i(nfcs_q), .doe_q_i(doe_q),
		.read_i(read_i), .fc_i(fc_i), .nds_q_i(nds_q), .addr_i(addr), .wdata_i(wdata),
		.card_en_i(card_en), .card_base_i(card_base), .cfg_en_i(cfg_en),
		.cfg_nibble_i(cfg_nibble), .mem(i_mem.master), .nslave_o(nslave_o),
		.ndtack_o(ndtack_o), .data_oe_o(data_oe_o), .ad_o(ad_o), .sd_o(sd_o),
		.cfg_wr_o(cfg_wr)
	);

	z3_autoconfig i_autoconfig (
		.clk(clk), .rst_n_i(rst_n), .ncfgin_i(ncfgin_i), .sensez3_i(sensez3_i),
		.cfg_wr_i(cfg_wr), .addr_i(addr), .wdata_i(wdata), .cfg_en_o(cfg_en),
		.cfg_nibble_o(cfg_nibble), .card_en_o(card_en), .card_base_o(card_base),
		.ncfgout_o(ncfgout_o)
	);

	z3_card_ram i_ram (
		.clk(clk), .rst_n_i(rst_n), .mem(i_mem.slave)
	);

endmodule

//--- tests/z3_bus_master.svh
// zorro iii bus master tasks: full slave cycles plus config and card wrappers, all waits bounded

// address phase, select, data phase, acknowledge, release
task automatic bus_cycle(input logic [31:0] addr, input logic rd, input logic [1:0] fc,
		input logic [31:0] word, input logic [3:0] be, input bit want_sel);
	int n;
	@(posedge clk);
	#1;
	ad_i   = addr[31:8];
	a_i    = addr[7:2];
	fc_i   = fc;
	read_i = rd;
	nfcs_i = 1'b0;
	// capture edge first, select follows one edge later
	n = 0;
	while (nslave_o && n < 8) begin
		@(posedge clk);
		#1;
		n++;
	end
	if (nslave_o && want_sel) fail_run("timeout: slave select never went low");
	if (!nslave_o) begin
		doe_i = 1'b1;
		if (!rd) begin
			// logical bytes go out on ad31..24, sd and ad23..8
			ad_i  = {word[31:24], word[15:0]};
			sd_i  = word[23:16];
			nds_i = ~be;
		end
		n = 0;
		while (ndtack_o && n < 16) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (ndtack_o) fail_run("timeout: data acknowledge never arrived");
		// hold one edge so the read checks see the acknowledge
		@(posedge clk);
		#1;
	end
	nfcs_i = 1'b1;
	doe_i  = 1'b0;
	nds_i  = 4'hf;
	n = 0;
	while (!nslave_o && n < 8) begin
		@(posedge clk);
		#1;
		n++;
	end
	if (!nslave_o) fail_run("timeout: slave select never released");
endtask

task automatic cfg_read(input logic [6:0] ofs, input logic [3:0] nib);
	exp_nib    = nib;
	chk_cfg_rd = 1'b1;
	bus_cycle({CFG_PAGE, 7'h00, ofs, 2'b00}, 1'b1, 2'b01, 32'h0, 4'h0, 1'b1);
	chk_cfg_rd = 1'b0;
endtask

// register byte rides on d31..24
task automatic cfg_write(input logic [6:0] ofs, input logic [7:0] data);
	bus_cycle({CFG_PAGE, 7'h00, ofs, 2'b00}, 1'b0, 2'b01, {data, 24'h0}, 4'h8, 1'b1);
endtask

task automatic card_write(input logic [31:0] addr, input logic [31:0] word,
		input logic [3:0] be);
	// scoreboard merge, strobe bit b guards logical byte b
	for (int b = 0; b < 4; b++) begin
		if (be[b]) sb[addr[9:2]][8*b +: 8] = word[8*b +: 8];
	end
	bus_cycle(addr, 1'b0, 2'b01, word, be, 1'b1);
endtask

task automatic card_read(input logic [31:0] addr);
	exp_word    = sb[addr[9:2]];
	chk_card_rd = 1'b1;
	bus_cycle(addr, 1'b1, 2'b01, 32'h0, 4'h0, 1'b1);
	chk_card_rd = 1'b0;
endtask

// cycle that the card must ignore
task automatic no_select(input logic [31:0] addr, input logic [1:0] fc);
	chk_nosel = 1'b1;
	bus_cycle(addr, 1'b1, fc, 32'h0, 4'h0, 1'b0);
	chk_nosel = 1'b0;
endtask

//--- tests/z3_memcard_tb.sv
// testbench for the zorro iii memory card: autoconfig, card ram, shut-up and chain pass-through
module z3_memcard_tb;
	import z3_pkg::*;

	logic        clk;
	logic        rst_n_i;
	logic        nfcs_i;
	logic        doe_i;
	logic        read_i;
	logic [1:0]  fc_i;
	logic [3:0]  nds_i;
	logic [31:8] ad_i;
	logic [7:2]  a_i;
	logic [7:0]  sd_i;
	logic        ncfgin_i;
	logic        iorst_n_i;
	logic        sensez3_i;
	logic        nslave_o;
	logic        ndtack_o;
	logic        ncfgout_o;
	logic [31:8] ad_o;
	logic [7:0]  sd_o;
	logic        data_oe_o;

	integer      seed = 32'h6772_48e6;
	logic [31:0] r;
	logic [7:0]  base;
	logic [7:0]  used [8];
	logic [31:0] sb [256];
	logic [3:0]  exp_nib;
	logic [31:0] exp_word;
	logic [3:0]  nib;
	bit          chk_rst, chk_cfg_rd, chk_card_rd, chk_nosel, chk_cfg_off, chk_chain;
	// contiguous strobe patterns, a few repeated to fill 16 slots
	logic [3:0]  masks [16] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h6, 4'hc, 4'h7,
		4'he, 4'hf, 4'hf, 4'h3, 4'hc, 4'h1, 4'h8, 4'hf};

	z3_memcard i_z3_memcard (
		.clk(clk), .rst_n_i(rst_n_i), .nfcs_i(nfcs_i), .doe_i(doe_i), .read_i(read_i),
		.fc_i(fc_i), .nds_i(nds_i), .ad_i(ad_i), .a_i(a_i), .sd_i(sd_i),
		.ncfgin_i(ncfgin_i), .iorst_n_i(iorst_n_i), .sensez3_i(sensez3_i),
		.nslave_o(nslave_o), .ndtack_o(ndtack_o), .ncfgout_o(ncfgout_o),
		.ad_o(ad_o), .sd_o(sd_o), .data_oe_o(data_oe_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		fail_run($sformatf("FAILED at %0t: %s", $time, msg));
	endtask

	`include "z3_bus_master.svh"

	task automatic apply_reset();
		rst_n_i = 1'b0;
		@(posedge clk);
		#1;
		chk_rst = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		// two edges after release still count as reset state
		repeat (2) @(posedge clk);
		#1;
		chk_rst = 1'b0;
	endtask

	// random spot in the card region, word index given
	function automatic logic [31:0] card_addr(input logic [7:0] idx);
		logic [31:0] rnd;
		rnd = $random(seed);
		return {base[7:1], rnd[24:10], idx, 2'b00};
	endfunction

	a_reset: assert property (@(posedge clk)
		chk_rst |-> (nslave_o && ndtack_o && ncfgout_o && !data_oe_o))
		else value_error("bus outputs active during or right after reset");
	a_rom: assert property (@(posedge clk) (chk_cfg_rd && !ndtack_o) |-> (ad_o[31:28] == exp_nib))
		else value_error($sformatf("rom nibble %h, expected %h", ad_o[31:28], exp_nib));
	a_ram: assert property (@(posedge clk)
		(chk_card_rd && !ndtack_o) |-> ({ad_o[31:24], sd_o, ad_o[23:8]} == exp_word))
		else value_error($sformatf("card read %h, expected %h",
			{ad_o[31:24], sd_o, ad_o[23:8]}, exp_word));
	// read data must actually be driven while acknowledged
	a_oe: assert property (@(posedge clk)
		((chk_cfg_rd || chk_card_rd) && !ndtack_o) |-> data_oe_o)
		else value_error("data output enable low while read data is acknowledged");
	a_nosel: assert property (@(posedge clk) chk_nosel |-> nslave_o)
		else value_error("slave select low on a cycle the card must ignore");
	a_cfgout: assert property (@(posedge clk) chk_cfg_off |-> !ncfgout_o)
		else value_error("config chain out still high after base or shut-up write");
	a_chain: assert property (@(posedge clk) chk_chain |-> (ncfgout_o == $past(ncfgin_i)))
		else value_error("config chain out does not follow chain in");

	initial begin
		{nfcs_i, doe_i, read_i, fc_i, nds_i} = {1'b1, 1'b0, 1'b1, 2'b01, 4'hf};
		{ad_i, a_i, sd_i} = '0;
		{ncfgin_i, iorst_n_i, sensez3_i} = {1'b0, 1'b1, 1'b1};
		apply_reset();
		// rom walk, type pair true, everything else inverted
		for (int o = 0; o <= 62; o++) begin
			nib = CFG_ROM[o[5:0]];
			if (o != 0 && o != 2) nib = ~nib;
			cfg_read(o[6:0], nib);
		end
		// keep the card clear of the config page
		r = $random(seed);
		base = {1'b0, r[6:0]};
		cfg_write(CFG_BASE_OFS, base);
		chk_cfg_off = 1'b1;
		no_select({CFG_PAGE, 16'h0000}, 2'b01);
		// full words first, then partial merges through aliases
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			used[i] = r[7:0];
			card_write(card_addr(used[i]), $random(seed), 4'hf);
		end
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			card_write(card_addr(used[r[2:0]]), $random(seed), masks[r[11:8]]);
		end
		for (int i = 0; i < 8; i++) card_read(card_addr(used[i]));
		no_select({base[7:1] ^ 7'h01, 25'h0}, 2'b01);
		no_select(card_addr(used[0]), 2'b00);
		no_select(card_addr(used[1]), 2'b11);
		// fresh card, shut up instead of configure
		chk_cfg_off = 1'b0;
		apply_reset();
		cfg_write(CFG_SHUTUP_OFS, 8'h00);
		chk_cfg_off = 1'b1;
		no_select(card_addr(used[2]), 2'b01);
		no_select({CFG_PAGE, 16'h0000}, 2'b01);
		chk_cfg_off = 1'b0;
		// non-z3 backplane, chain passes straight through
		sensez3_i = 1'b0;
		ncfgin_i  = 1'b1;
		apply_reset();
		chk_chain = 1'b1;
		for (int i = 0; i < 12; i++) begin
			@(posedge clk);
			#1;
			r = $random(seed);
			ncfgin_i = r[0];
		end
		ncfgin_i = 1'b0;
		no_select({CFG_PAGE, 16'h0000}, 2'b01);
		chk_chain = 1'b0;
		// configured card drops off the bus once sense goes low
		sensez3_i = 1'b1;
		cfg_write(CFG_BASE_OFS, base);
		sensez3_i = 1'b0;
		no_select(card_addr(used[3]), 2'b01);
		$display("Verification passed");
		$finish;
	end

endmodule

//--- z3_memcard.f
+incdir+tests
design/z3_pkg.sv
design/mem_req_if.sv
design/z3_bus_sampler.sv
design/z3_slave_fsm.sv
design/z3_autoconfig.sv
design/z3_card_ram.sv
design/z3_memcard.sv
tests/z3_memcard_tb.sv

//--- Makefile
SIM := obj_dir/Vz3_memcard_tb

.PHONY: all run clean

all: run

$(SIM): z3_memcard.f $(wildcard design/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
	verilator --binary --timing --assert -f z3_memcard.f --top-module z3_memcard_tb -o Vz3_memcard_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
